// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_max7219 -f verilog.f > build.log 2>&1 \
   && ./obj_dir/Vtb_max7219 +verilator+error+limit+1000 > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "Testbench failed" sim.log 2>/dev/null && exit 1
grep -q "Testbench passed" sim.log 2>/dev/null || exit 1
exit 0

// ==== verif/display_input.dat ====
// display_value, then expected segment bytes for digit 1 to digit 8
// digit 1 shows the lowest nibble
00000000 7E 7E 7E 7E 7E 7E 7E 7E
12345678 7F 70 5F 5B 33 79 6D 30
89ABCDEF 47 4F 3D 4E 1F 77 7B 7F
FFFFFFFF 47 47 47 47 47 47 47 47
DEADBEEF 47 4F 4F 1F 3D 77 4F 3D
0F1E2D3C 4E 79 3D 6D 4F 30 47 7E
76543210 7E 30 6D 79 33 5B 5F 70
A5A5A5A5 5B 77 5B 77 5B 77 5B 77

// ==== verif/max7219_assert.sv ====
`timescale 1ns/1ps

module max7219_assert (
   input logic clk,
   input logic rst_n,
   input logic max_clk,
   input logic max_load
);

   // serial clock parked low while the frame latches
   clk_load_apart: assert property (@(posedge clk) !(max_clk && max_load))
      else $error("max_clk and max_load high in the same cycle");

   load_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n) max_load |=> !max_load)
      else $error("max_load held high for more than one cycle");

   load_low_in_reset: assert property (@(posedge clk) !rst_n |-> !max_load)
      else $error("max_load high while in reset");

endmodule

bind max7219_top max7219_assert max7219_assert_inst (
   .clk      (clk),
   .rst_n    (rst_n),
   .max_clk  (max_clk),
   .max_load (max_load)
);

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        max_din,
   input  logic        max_clk,
   input  logic        max_load,
   input  logic        new_value,
   input  logic [63:0] expected_segs, // digit 1 in the low byte
   output int          frame_count,   // frames since last reset
   output int          scan_count,    // finished scans since new_value
   output int          error_count,
   output int          framing_errors
);

   logic [15:0] setup_table [0:5];
   logic [7:0]  scan_bytes [0:7];
   logic [15:0] shift_bits;
   int          bit_count;
   logic        armed;
   logic        prev_clk;
   logic        prev_load;

   initial begin
      setup_table[0] = 16'h0000;
      setup_table[1] = 16'h0F00; // display test off
      setup_table[2] = 16'h0B07; // scan all 8 digits
      setup_table[3] = 16'h0900; // no decode
      setup_table[4] = 16'h0C01; // out of shutdown
      setup_table[5] = 16'h0A07;
      frame_count    = 0;
      scan_count     = 0;
      error_count    = 0;
      framing_errors = 0;
      bit_count      = 0;
      shift_bits     = '0;
      armed          = 1'b0;
      prev_clk       = 1'b0;
      prev_load      = 1'b0;
   end

   task automatic compare_value(input string name, input logic [15:0] want,
                                input logic [15:0] got);
      if (want !== got) begin
         error_count++;
         $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, want, got);
      end
   endtask

   task automatic report_framing(input string what);
      framing_errors++;
      error_count++;
      $display("frame %0d: %s", frame_count, what);
   endtask

   task automatic check_frame();
      int digit;
      int d;
      if (bit_count != 16) begin
         report_framing($sformatf("%0d serial clock edges instead of 16", bit_count));
      end
      if (frame_count < 6) begin
         compare_value($sformatf("max_din setup frame %0d", frame_count),
                       setup_table[frame_count], shift_bits);
      end else begin
         digit = (frame_count - 6) % 8;
         compare_value($sformatf("max_din opcode of frame %0d", frame_count),
                       16'(digit + 1), {8'h00, shift_bits[15:8]});
         scan_bytes[digit] = shift_bits[7:0];
         if (digit == 7) begin
            scan_count++;
            // first scan after a change may still carry the old snapshot
            if (armed && scan_count == 2) begin
               for (d = 0; d < 8; d++) begin
                  compare_value($sformatf("max_din digit %0d segments", d + 1),
                                {8'h00, expected_segs[d*8 +: 8]}, {8'h00, scan_bytes[d]});
               end
            end
         end
      end
   endtask

   // pins sampled on clk, edges seen one cycle late
   always @(posedge clk) begin
      if (new_value) begin
         scan_count = 0;
         armed      = 1'b1;
      end
      if (!rst_n) begin
         frame_count = 0; // partial frame is dropped
         bit_count   = 0;
         if (max_load) begin
            report_framing("max_load high during reset");
         end
      end else begin
         if (max_clk && !prev_clk) begin
            shift_bits = {shift_bits[14:0], max_din};
            bit_count++;
         end
         if (max_load && max_clk) begin
            report_framing("max_load and max_clk high together");
         end
         if (max_load && prev_load) begin
            report_framing("max_load high for more than one cycle");
         end else if (max_load) begin
            check_frame();
            bit_count = 0;
            frame_count++;
         end
      end
      prev_clk  = max_clk;
      prev_load = max_load;
   end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter int HALF_PERIOD  = 10, // ns, 20 ns clock
   parameter int RESET_CYCLES = 16
) (
   input  logic reset_req,
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // power-on reset, then one more per request
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      forever begin
         @(posedge clk);
         if (reset_req) begin
            @(negedge clk);
            rst_n = 1'b0;
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
         end
      end
   end

endmodule

// ==== verif/tb_max7219.sv ====
`timescale 1ns/1ps

module tb_max7219;

   localparam int NUM_ROWS   = 8;
   localparam int ROW_WORDS  = 9;    // value, then 8 segment bytes
   localparam int WAIT_LIMIT = 5000; // clk cycles per wait

   logic                     clk;
   logic                     rst_n;
   logic                     reset_req;
   display_pkg::disp_value_t display_value;
   logic                     max_din;
   logic                     max_clk;
   logic                     max_load;
   logic                     new_value;
   logic [63:0]              expected_segs;
   int                       frame_count;
   int                       scan_count;
   int                       error_count;
   int                       framing_errors;
   logic [31:0]              stim_mem [0:NUM_ROWS*ROW_WORDS-1];
   int                       test_count;
   int                       test_fails;
   logic                     timed_out;

   tb_clock tb_clock_inst (
      .reset_req (reset_req),
      .clk       (clk),
      .rst_n     (rst_n)
   );

   max7219_top #(
      .CLK_DIV (2)
   ) max7219_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .display_value (display_value),
      .max_din       (max_din),
      .max_clk       (max_clk),
      .max_load      (max_load)
   );

   tb_checker tb_checker_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .max_din        (max_din),
      .max_clk        (max_clk),
      .max_load       (max_load),
      .new_value      (new_value),
      .expected_segs  (expected_segs),
      .frame_count    (frame_count),
      .scan_count     (scan_count),
      .error_count    (error_count),
      .framing_errors (framing_errors)
   );

   function automatic int watched_count(input int sel);
      case (sel)
         0:       return frame_count;
         1:       return scan_count;
         2:       return int'(!rst_n);
         default: return int'(rst_n);
      endcase
   endfunction

   task automatic wait_until_reaches(input int sel, input int target, input string what);
      int cycles;
      cycles = 0;
      while (!timed_out && watched_count(sel) < target) begin
         if (cycles == WAIT_LIMIT) begin
            $display("timeout while waiting for %s", what);
            timed_out = 1'b1;
         end else begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      if (timed_out || error_count != errs_before) begin
         test_fails++;
         $display("test %0d %s: FAILED", test_count, name);
      end else begin
         $display("test %0d %s: ok", test_count, name);
      end
   endtask

   task automatic apply_row(input int row);
      int errs;
      int base;
      int d;
      errs = error_count;
      base = row * ROW_WORDS;
      @(negedge clk);
      display_value = stim_mem[base];
      for (d = 0; d < 8; d++) begin
         expected_segs[d*8 +: 8] = stim_mem[base + 1 + d][7:0];
      end
      new_value = 1'b1;
      @(negedge clk);
      new_value = 1'b0;
      wait_until_reaches(1, 2, "two scans of a new value");
      finish_test($sformatf("value 0x%08h", display_value), errs);
   endtask

   initial begin
      int errs;
      int row;
      display_value = '0;
      new_value     = 1'b0;
      expected_segs = '0;
      reset_req     = 1'b0;
      timed_out     = 1'b0;
      test_count    = 0;
      test_fails    = 0;
      $readmemh("verif/display_input.dat", stim_mem);

      errs = error_count;
      wait_until_reaches(0, 6, "setup frames after power-on");
      finish_test("setup frames", errs);

      errs = error_count;
      wait_until_reaches(0, 6 + 2 * 8, "two digit scans");
      finish_test("digit order", errs);

      for (row = 0; row < NUM_ROWS; row++) begin
         if (!timed_out) begin
            apply_row(row);
         end
      end

      // reset lands partway into a frame
      errs = error_count;
      wait_until_reaches(0, frame_count + 3, "frames before reset");
      repeat (20) @(negedge clk);
      reset_req = 1'b1;
      @(negedge clk);
      reset_req = 1'b0;
      wait_until_reaches(2, 1, "rst_n low");
      wait_until_reaches(3, 1, "rst_n high again"); // checker frame count is back to 0
      wait_until_reaches(0, 6, "setup frames after mid-run reset");
      finish_test("reset in mid frame", errs);

      test_count++;
      if (framing_errors == 0) begin
         $display("test %0d framing over the run: ok", test_count);
      end else begin
         test_fails++;
         $display("test %0d framing over the run: FAILED", test_count);
      end

      $display("tests %0d, failed %0d, checker errors %0d", test_count, test_fails,
               error_count);
      if (test_fails == 0 && error_count == 0 && !timed_out) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
verilog/max7219_reg_pkg.sv
verilog/display_pkg.sv
verilog/spi_shifter.sv
verilog/digit_scanner.sv
verilog/max_sequencer.sv
verilog/max7219_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/max7219_assert.sv
verif/tb_max7219.sv

// ==== verilog/digit_scanner.sv ====
`timescale 1ns/1ps

module digit_scanner (
   input  logic                        clk,
   input  logic                        rst_n,
   input  display_pkg::disp_value_t    display_value,
   input  logic                        frame_taken,
   output max7219_reg_pkg::max_frame_t digit_frame
);

   localparam display_pkg::digit_idx_t LAST_IDX =
      display_pkg::digit_idx_t'(display_pkg::NUM_DIGITS - 1);

   display_pkg::disp_value_t snap_q;
   display_pkg::digit_idx_t  idx_q;
   display_pkg::nibble_t     nib;

   // index steps once per digit frame the sequencer takes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx_q <= '0;
      end else if (frame_taken) begin
         if (idx_q == LAST_IDX) begin
            idx_q <= '0; // wrap back to digit 1
         end else begin
            idx_q <= idx_q + 3'd1;
         end
      end
   end

   // snapshot tracks the input until digit 1 goes out,
   // then holds for the rest of the scan
   always_ff @(posedge clk) begin
      if (idx_q == '0 && !frame_taken) begin
         snap_q <= display_value;
      end
   end

   always_comb begin
      nib = snap_q[idx_q*4 +: 4]; // digit 1 is the lowest nibble
      digit_frame.opcode = max7219_reg_pkg::max_opcode_t'({5'd0, idx_q} + 8'd1);
      digit_frame.data   = display_pkg::seg_encode(nib);
   end

endmodule

// ==== verilog/display_pkg.sv ====
package display_pkg;

   typedef logic [31:0] disp_value_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [7:0]  seg_byte_t;  // dp a b c d e f g
   typedef logic [2:0]  digit_idx_t; // 0 is digit 1

   localparam int NUM_DIGITS = 8;

   typedef enum logic [2:0] {
      SETUP_PICK,
      SEND_OP,
      WAIT_OP,
      SEND_DATA,
      WAIT_DATA,
      LATCH
   } seq_state_t;

   // hex glyphs, dp always off
   function automatic seg_byte_t seg_encode(input nibble_t nib);
      case (nib)
         4'h0: return 8'h7E;
         4'h1: return 8'h30;
         4'h2: return 8'h6D;
         4'h3: return 8'h79;
         4'h4: return 8'h33;
         4'h5: return 8'h5B;
         4'h6: return 8'h5F;
         4'h7: return 8'h70;
         4'h8: return 8'h7F;
         4'h9: return 8'h7B;
         4'hA: return 8'h77;
         4'hB: return 8'h1F; // lower case b
         4'hC: return 8'h4E;
         4'hD: return 8'h3D; // lower case d
         4'hE: return 8'h4F;
         default: return 8'h47;
      endcase
   endfunction

endpackage

// ==== verilog/max7219_reg_pkg.sv ====
package max7219_reg_pkg;

   typedef enum logic [7:0] {
      NOP          = 8'h00,
      DIGIT_1      = 8'h01,
      DIGIT_2      = 8'h02,
      DIGIT_3      = 8'h03,
      DIGIT_4      = 8'h04,
      DIGIT_5      = 8'h05,
      DIGIT_6      = 8'h06,
      DIGIT_7      = 8'h07,
      DIGIT_8      = 8'h08,
      DECODE_MODE  = 8'h09,
      INTENSITY    = 8'h0A,
      SCAN_LIMIT   = 8'h0B,
      SHUTDOWN     = 8'h0C,
      DISPLAY_TEST = 8'h0F
   } max_opcode_t;

   // goes out opcode first, msb first
   typedef struct packed {
      max_opcode_t opcode;
      logic [7:0]  data;
   } max_frame_t;

   localparam int SETUP_FRAMES = 6;

   // power-up register writes, in sending order
   function automatic max_frame_t setup_frame(input int unsigned idx);
      case (idx)
         0:       return '{opcode: NOP,          data: 8'h00}; // flushes a stale shift reg
         1:       return '{opcode: DISPLAY_TEST, data: 8'h00};
         2:       return '{opcode: SCAN_LIMIT,   data: 8'h07}; // all 8 digits
         3:       return '{opcode: DECODE_MODE,  data: 8'h00}; // raw segments, no code b
         4:       return '{opcode: SHUTDOWN,     data: 8'h01}; // normal operation
         default: return '{opcode: INTENSITY,    data: 8'h07};
      endcase
   endfunction

endpackage

// ==== verilog/max7219_top.sv ====
`timescale 1ns/1ps

module max7219_top #(
   parameter int CLK_DIV = 10 // system clocks per serial clock half period
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  display_pkg::disp_value_t display_value,
   output logic                     max_din,
   output logic                     max_clk,
   output logic                     max_load
);

   max7219_reg_pkg::max_frame_t digit_frame;
   logic                        frame_taken;
   logic                        start;
   logic [7:0]                  tx_byte;
   logic                        byte_done;

   max_sequencer max_sequencer_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .digit_frame (digit_frame),
      .frame_taken (frame_taken),
      .start       (start),
      .tx_byte     (tx_byte),
      .byte_done   (byte_done),
      .max_load    (max_load)
   );

   spi_shifter #(
      .CLK_DIV (CLK_DIV)
   ) spi_shifter_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .tx_byte   (tx_byte),
      .byte_done (byte_done),
      .max_din   (max_din),
      .max_clk   (max_clk)
   );

   digit_scanner digit_scanner_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .display_value (display_value),
      .frame_taken   (frame_taken),
      .digit_frame   (digit_frame)
   );

endmodule

// ==== verilog/max_sequencer.sv ====
`timescale 1ns/1ps

module max_sequencer (
   input  logic                        clk,
   input  logic                        rst_n,
   input  max7219_reg_pkg::max_frame_t digit_frame,
   output logic                        frame_taken,
   output logic                        start,
   output logic [7:0]                  tx_byte,
   input  logic                        byte_done,
   output logic                        max_load
);

   localparam int IW = $clog2(max7219_reg_pkg::SETUP_FRAMES);
   localparam logic [IW-1:0] LAST_SETUP = IW'(max7219_reg_pkg::SETUP_FRAMES - 1);

   display_pkg::seq_state_t     state_q;
   logic [IW-1:0]               setup_idx_q;
   logic                        setup_done_q;
   max7219_reg_pkg::max_frame_t frame_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= display_pkg::SETUP_PICK;
         setup_idx_q  <= '0;
         setup_done_q <= 1'b0;
      end else begin
         case (state_q)
            display_pkg::SETUP_PICK: begin
               if (!setup_done_q) begin
                  if (setup_idx_q == LAST_SETUP) begin
                     setup_done_q <= 1'b1;
                  end else begin
                     setup_idx_q <= setup_idx_q + 1'b1;
                  end
               end
               state_q <= display_pkg::SEND_OP;
            end
            display_pkg::SEND_OP: begin
               state_q <= display_pkg::WAIT_OP;
            end
            display_pkg::WAIT_OP: begin
               if (byte_done) begin
                  state_q <= display_pkg::SEND_DATA;
               end
            end
            display_pkg::SEND_DATA: begin
               state_q <= display_pkg::WAIT_DATA;
            end
            display_pkg::WAIT_DATA: begin
               if (byte_done) begin
                  state_q <= display_pkg::LATCH;
               end
            end
            display_pkg::LATCH: begin
               state_q <= display_pkg::SETUP_PICK; // straight into the next frame
            end
            default: begin
               state_q <= display_pkg::SETUP_PICK;
            end
         endcase
      end
   end

   // frame being sent, picked from the table or the scanner
   always_ff @(posedge clk) begin
      if (state_q == display_pkg::SETUP_PICK) begin
         if (setup_done_q) begin
            frame_q <= digit_frame;
         end else begin
            frame_q <= max7219_reg_pkg::setup_frame(setup_idx_q);
         end
      end
   end

   assign frame_taken = (state_q == display_pkg::SETUP_PICK) && setup_done_q;

   assign start = (state_q == display_pkg::SEND_OP) || (state_q == display_pkg::SEND_DATA);
   assign tx_byte = (state_q == display_pkg::SEND_OP) ? frame_q.opcode : frame_q.data;

   // shifter is idle here, so max_clk is already low
   assign max_load = (state_q == display_pkg::LATCH);

endmodule

// ==== verilog/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter #(
   parameter int CLK_DIV = 10
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   input  logic [7:0] tx_byte,
   output logic       byte_done,
   output logic       max_din,
   output logic       max_clk
);

   // one opcode or data byte per transfer
   localparam int NBITS = $bits(max7219_reg_pkg::max_opcode_t);
   localparam int PW    = $clog2(CLK_DIV + 1);
   localparam logic [PW-1:0] LAST_PHASE = PW'(CLK_DIV - 1);
   localparam logic [2:0]    LAST_BIT   = 3'(NBITS - 1);

   logic [7:0]    shift_q;
   logic [2:0]    bit_q;
   logic [PW-1:0] phase_q;
   logic          busy_q;
   logic          clk_q;
   logic          done_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shift_q <= '0;
         bit_q   <= '0;
         phase_q <= '0;
         busy_q  <= 1'b0;
         clk_q   <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (!busy_q) begin
            if (start) begin
               busy_q  <= 1'b1;
               shift_q <= tx_byte;
               bit_q   <= '0;
               phase_q <= '0;
            end
         end else if (phase_q == LAST_PHASE) begin
            phase_q <= '0;
            if (!clk_q) begin
               clk_q <= 1'b1; // display samples here
            end else begin
               clk_q <= 1'b0;
               if (bit_q == LAST_BIT) begin
                  busy_q <= 1'b0;
                  done_q <= 1'b1;
               end else begin
                  bit_q   <= bit_q + 3'd1;
                  shift_q <= {shift_q[6:0], 1'b0}; // next bit during low phase
               end
            end
         end else begin
            phase_q <= phase_q + 1'b1;
         end
      end
   end

   assign max_din   = shift_q[7];
   assign max_clk   = clk_q;
   assign byte_done = done_q;

endmodule
